//--- verilog/obj_pkg.sv
/*
    Sprite layer definitions
    Object table geometry, entry field layout, graphics ROM and
    line buffer widths, and the video timing of one line and frame
*/
package obj_pkg;

    // Object table geometry
    localparam int OBJ_NUM   = 64;
    localparam int OBJ_WORDS = 4;
    localparam int WSEL_W    = 2;
    localparam int TBL_AW    = 8;
    localparam int TBL_DW    = 16;
    localparam int COPY_LEN  = OBJ_NUM * OBJ_WORDS;

    // Word order inside one entry
    localparam int W_YPOS = 0;
    localparam int W_XPOS = 1;
    localparam int W_CODE = 2;
    localparam int W_PAL  = 3;

    // Field positions and widths
    localparam int EN_BIT    = 15;
    localparam int POS_W     = 8;
    localparam int HFLIP_BIT = 8;
    localparam int CODE_W    = 12;
    localparam int PAL_W     = 4;

    // Sprite cell and graphics ROM
    localparam int OBJ_SIZE = 16;
    localparam int ROW_W    = 4;
    localparam int NIB_W    = 4;
    localparam int HALF_PIX = 8;
    localparam int PCNT_W   = 3;
    localparam int ROM_AW   = 17;
    localparam int ROM_DW   = 32;

    // Line buffer, palette then colour
    localparam int PXL_W   = 8;
    localparam int LINE_W  = 256;
    localparam int LINE_AW = 8;

    // Video timing
    localparam int LINE_CLKS   = 1280;
    localparam int PXL_DIV     = 4;
    localparam int LINE_PIX    = 320;
    localparam int FRAME_LINES = 264;

endpackage

//--- verilog/obj_buffer.sv
/*
    Object table buffer
    CPU object RAM with byte-masked writes and registered readback.
    A copy pulse moves the whole table, one word per clock, into
    the shadow table that the line scanner reads.
*/
module obj_buffer (
    input  logic                       clk,
    input  logic                       arst_n,
    // CPU port
    input  logic [obj_pkg::TBL_AW-1:0] cpu_addr,
    input  logic [obj_pkg::TBL_DW-1:0] cpu_dout,
    input  logic [1:0]                 cpu_dsn,
    input  logic                       cpu_rnw,
    input  logic                       objram_cs,
    output logic [obj_pkg::TBL_DW-1:0] obj_dout,
    // Copy trigger
    input  logic                       obj_copy,
    // Shadow table port
    input  logic [obj_pkg::TBL_AW-1:0] tbl_addr,
    output logic [obj_pkg::TBL_DW-1:0] tbl_dout
);

    logic [obj_pkg::TBL_DW-1:0] cpu_ram [0:obj_pkg::COPY_LEN-1];
    logic [obj_pkg::TBL_DW-1:0] shd_ram [0:obj_pkg::COPY_LEN-1];

    logic                       cpu_we;
    logic                       copy_on;
    logic [obj_pkg::TBL_AW-1:0] copy_cnt;
    logic                       copy_we;
    logic [obj_pkg::TBL_AW-1:0] copy_wa;
    logic [obj_pkg::TBL_DW-1:0] copy_data;

    assign cpu_we = objram_cs && !cpu_rnw;

    // CPU side memory
    // Active-low byte enables, dsn[1] for the upper byte
    always_ff @(posedge clk) begin
        if (cpu_we && !cpu_dsn[1]) begin
            cpu_ram[cpu_addr][15:8] <= cpu_dout[15:8];
        end
        if (cpu_we && !cpu_dsn[0]) begin
            cpu_ram[cpu_addr][7:0] <= cpu_dout[7:0];
        end
        // Readback one clock after the address
        obj_dout  <= cpu_ram[cpu_addr];
        // Copy read, written to the shadow a clock later
        copy_data <= cpu_ram[copy_cnt];
        copy_wa   <= copy_cnt;
    end

    // Copy sequencer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            copy_on  <= 1'b0;
            copy_cnt <= '0;
            copy_we  <= 1'b0;
        end else begin
            copy_we <= copy_on;
            if (obj_copy) begin
                // A new pulse restarts from word 0
                copy_on  <= 1'b1;
                copy_cnt <= '0;
            end else if (copy_on) begin
                copy_cnt <= copy_cnt + 1'b1;
                // Table fills the whole word address space
                if (copy_cnt == '1) begin
                    copy_on <= 1'b0;
                end
            end
        end
    end

    // Shadow table, scanner side
    always_ff @(posedge clk) begin
        if (copy_we) begin
            shd_ram[copy_wa] <= copy_data;
        end
        tbl_dout <= shd_ram[tbl_addr];
    end

endmodule

//--- verilog/obj_scan.sv
/*
    Sprite line scanner
    At each line start, walks the shadow table for the next line
    and offers every visible entry as a descriptor to the draw
    engine over valid/ready.
*/
module obj_scan (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       hinit,
    input  logic [obj_pkg::POS_W-1:0]  vdump,
    // Shadow table
    output logic [obj_pkg::TBL_AW-1:0] tbl_addr,
    input  logic [obj_pkg::TBL_DW-1:0] tbl_dout,
    // Descriptor to draw engine
    output logic                       spr_valid,
    input  logic                       spr_ready,
    output logic [obj_pkg::POS_W-1:0]  spr_x,
    output logic [obj_pkg::ROW_W-1:0]  spr_row,
    output logic [obj_pkg::CODE_W-1:0] spr_code,
    output logic [obj_pkg::PAL_W-1:0]  spr_pal,
    output logic                       spr_hflip
);

    logic                       scan_on;
    logic                       stall;
    logic                       rd_ok;
    logic [obj_pkg::TBL_AW-1:0] ptr;
    logic [obj_pkg::WSEL_W-1:0] rd_w;
    logic [obj_pkg::POS_W-1:0]  target;
    logic [obj_pkg::POS_W-1:0]  dy;
    logic                       hit;

    // Entry fields gathered word by word
    logic                       ent_en;
    logic [obj_pkg::POS_W-1:0]  ent_y;
    logic [obj_pkg::POS_W-1:0]  ent_x;
    logic                       ent_hflip;
    logic [obj_pkg::CODE_W-1:0] ent_code;

    // Pointer is entry index then word select
    assign tbl_addr = ptr;
    assign stall    = spr_valid && !spr_ready;
    // Row inside the sprite, wraps past line 255
    assign dy       = target - ent_y;
    // Decided when the palette word arrives
    assign hit = rd_ok && (rd_w == obj_pkg::W_PAL) && ent_en && (dy < obj_pkg::OBJ_SIZE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_on   <= 1'b0;
            ptr       <= '0;
            rd_ok     <= 1'b0;
            rd_w      <= '0;
            spr_valid <= 1'b0;
        end else if (hinit) begin
            // Unfinished walk is dropped
            scan_on   <= 1'b1;
            ptr       <= '0;
            rd_ok     <= 1'b0;
            spr_valid <= 1'b0;
        end else begin
            // Held address during a stall is not captured twice
            rd_ok <= scan_on && !stall;
            rd_w  <= ptr[obj_pkg::WSEL_W-1:0];
            if (scan_on && !stall) begin
                ptr <= ptr + 1'b1;
                // Last word of entry 63 issued
                if (ptr == '1) begin
                    scan_on <= 1'b0;
                end
            end
            if (hit) begin
                spr_valid <= 1'b1;
            end else if (spr_ready) begin
                spr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hinit) begin
            target <= vdump + 1'b1;
        end
        if (rd_ok) begin
            case (rd_w)
                obj_pkg::W_YPOS: begin
                    ent_en <= tbl_dout[obj_pkg::EN_BIT];
                    ent_y  <= tbl_dout[obj_pkg::POS_W-1:0];
                end
                obj_pkg::W_XPOS: begin
                    ent_x     <= tbl_dout[obj_pkg::POS_W-1:0];
                    ent_hflip <= tbl_dout[obj_pkg::HFLIP_BIT];
                end
                obj_pkg::W_CODE: begin
                    ent_code <= tbl_dout[obj_pkg::CODE_W-1:0];
                end
                default: ;
            endcase
        end
        // Palette comes straight from the table read
        if (hit) begin
            spr_x     <= ent_x;
            spr_row   <= dy[obj_pkg::ROW_W-1:0];
            spr_code  <= ent_code;
            spr_pal   <= tbl_dout[obj_pkg::PAL_W-1:0];
            spr_hflip <= ent_hflip;
        end
    end

endmodule

//--- verilog/obj_draw.sv
/*
    Sprite draw engine
    Takes one descriptor at a time, fetches the two ROM halves of
    the sprite row and writes 16 pixels into the line buffer.
    Horizontal flip swaps the halves and the nibble order.
*/
module obj_draw (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        hinit,
    // Descriptor from scanner
    input  logic                        spr_valid,
    output logic                        spr_ready,
    input  logic [obj_pkg::POS_W-1:0]   spr_x,
    input  logic [obj_pkg::ROW_W-1:0]   spr_row,
    input  logic [obj_pkg::CODE_W-1:0]  spr_code,
    input  logic [obj_pkg::PAL_W-1:0]   spr_pal,
    input  logic                        spr_hflip,
    // Graphics ROM
    output logic                        rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]  rom_addr,
    input  logic [obj_pkg::ROM_DW-1:0]  rom_data,
    input  logic                        rom_ok,
    // Line buffer writes
    output logic                        buf_we,
    output logic [obj_pkg::LINE_AW-1:0] buf_addr,
    output logic [obj_pkg::PXL_W-1:0]   buf_data
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DRAW
    } state_t;

    state_t                     state;
    logic                       accept;
    logic                       half;
    logic [obj_pkg::PCNT_W-1:0] pcnt;
    logic [obj_pkg::PCNT_W-1:0] nsel;
    logic [obj_pkg::NIB_W-1:0]  nib;
    logic [obj_pkg::ROM_DW-1:0] gfx;

    // Latched descriptor
    logic [obj_pkg::POS_W-1:0]  x;
    logic [obj_pkg::ROW_W-1:0]  row;
    logic [obj_pkg::CODE_W-1:0] code;
    logic [obj_pkg::PAL_W-1:0]  pal;
    logic                       hflip;

    assign spr_ready = (state == IDLE);
    assign accept    = spr_valid && spr_ready;

    // Code, row, half select
    // Flipped sprites fetch the right half first
    assign rom_addr = {code, row, half ^ hflip};

    // Unflipped rows start at the top nibble
    assign nsel = hflip ? pcnt : ~pcnt;
    assign nib  = gfx[nsel*obj_pkg::NIB_W +: obj_pkg::NIB_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            rom_cs <= 1'b0;
            half   <= 1'b0;
            pcnt   <= '0;
            buf_we <= 1'b0;
        end else if (hinit) begin
            // Line over, drop the sprite in progress
            state  <= IDLE;
            rom_cs <= 1'b0;
            buf_we <= 1'b0;
        end else begin
            buf_we <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state  <= FETCH;
                        rom_cs <= 1'b1;
                        half   <= 1'b0;
                    end
                end
                FETCH: begin
                    // Request held until the ROM answers
                    if (rom_ok) begin
                        state  <= DRAW;
                        rom_cs <= 1'b0;
                        pcnt   <= '0;
                    end
                end
                DRAW: begin
                    // Colour 0 is transparent
                    buf_we <= (nib != '0);
                    pcnt   <= pcnt + 1'b1;
                    if (pcnt == '1) begin
                        if (!half) begin
                            half   <= 1'b1;
                            state  <= FETCH;
                            rom_cs <= 1'b1;
                        end else begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            x     <= spr_x;
            row   <= spr_row;
            code  <= spr_code;
            pal   <= spr_pal;
            hflip <= spr_hflip;
        end
        if (state == FETCH && rom_ok) begin
            gfx <= rom_data;
        end
        // Column wraps at 256
        buf_addr <= x + {{(obj_pkg::LINE_AW-obj_pkg::PCNT_W-1){1'b0}}, half, pcnt};
        buf_data <= {pal, nib};
    end

endmodule

//--- verilog/obj_linebuf.sv
/*
    Double-buffered sprite line buffer
    One bank takes draw writes while the other plays the previous
    line out at the pixel rate and is cleared behind the read.
    Banks swap at each line start.
*/
module obj_linebuf (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        hinit,
    input  logic                        pxl_cen,
    input  logic                        LHBL,
    input  logic                        LVBL,
    input  logic [obj_pkg::LINE_AW-1:0] hdump,
    // Draw engine writes
    input  logic                        buf_we,
    input  logic [obj_pkg::LINE_AW-1:0] buf_addr,
    input  logic [obj_pkg::PXL_W-1:0]   buf_data,
    output logic [obj_pkg::PXL_W-1:0]   pxl
);

    logic [obj_pkg::PXL_W-1:0] bank [0:1][0:obj_pkg::LINE_W-1];

    logic                      wr_sel;
    logic                      rd_sel;
    logic                      free;
    logic [obj_pkg::PXL_W-1:0] rd_q;

    // Empty entry has colour 0
    // First sprite written keeps the pixel
    assign free = (bank[wr_sel][buf_addr][obj_pkg::NIB_W-1:0] == '0);

    // Line start clock already reads the bank just drawn
    assign rd_sel = hinit ? wr_sel : !wr_sel;

    // Bank select
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_sel <= 1'b0;
        end else if (hinit) begin
            wr_sel <= ~wr_sel;
        end
    end

    always_ff @(posedge clk) begin
        // Write bank with read-check-write
        if (buf_we && free) begin
            bank[wr_sel][buf_addr] <= buf_data;
        end
        // Read bank is cleared for its next turn as write bank
        if (pxl_cen) begin
            rd_q                <= bank[rd_sel][hdump];
            bank[rd_sel][hdump] <= '0;
        end
    end

    // One pixel-enable behind the read
    // blanked outside the active area
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= (LHBL && LVBL) ? rd_q : '0;
        end
    end

endmodule

//--- verilog/obj_top.sv
/*
    Sprite layer top
    Object table buffer, line scanner, draw engine and line buffer
*/
module obj_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pxl_cen,
    // Video timing
    input  logic                        LHBL,
    input  logic                        LVBL,
    input  logic                        hinit,
    input  logic [obj_pkg::POS_W-1:0]   vdump,
    input  logic [obj_pkg::LINE_AW-1:0] hdump,
    // CPU port
    input  logic [obj_pkg::TBL_AW-1:0]  cpu_addr,
    input  logic [obj_pkg::TBL_DW-1:0]  cpu_dout,
    input  logic [1:0]                  cpu_dsn,
    input  logic                        cpu_rnw,
    input  logic                        objram_cs,
    input  logic                        obj_copy,
    output logic [obj_pkg::TBL_DW-1:0]  obj_dout,
    // Graphics ROM
    output logic                        rom_cs,
    output logic [obj_pkg::ROM_AW-1:0]  rom_addr,
    input  logic [obj_pkg::ROM_DW-1:0]  rom_data,
    input  logic                        rom_ok,
    output logic [obj_pkg::PXL_W-1:0]   pxl
);

    // Shadow table
    logic [obj_pkg::TBL_AW-1:0]  tbl_addr;
    logic [obj_pkg::TBL_DW-1:0]  tbl_dout;

    // Scanner to draw engine
    logic                        spr_valid;
    logic                        spr_ready;
    logic [obj_pkg::POS_W-1:0]   spr_x;
    logic [obj_pkg::ROW_W-1:0]   spr_row;
    logic [obj_pkg::CODE_W-1:0]  spr_code;
    logic [obj_pkg::PAL_W-1:0]   spr_pal;
    logic                        spr_hflip;

    // Draw engine to line buffer
    logic                        buf_we;
    logic [obj_pkg::LINE_AW-1:0] buf_addr;
    logic [obj_pkg::PXL_W-1:0]   buf_data;

    obj_buffer u_buffer (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .cpu_dsn    ( cpu_dsn    ),
        .cpu_rnw    ( cpu_rnw    ),
        .objram_cs  ( objram_cs  ),
        .obj_dout   ( obj_dout   ),
        .obj_copy   ( obj_copy   ),
        .tbl_addr   ( tbl_addr   ),
        .tbl_dout   ( tbl_dout   )
    );

    obj_scan u_scan (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .hinit      ( hinit      ),
        .vdump      ( vdump      ),
        .tbl_addr   ( tbl_addr   ),
        .tbl_dout   ( tbl_dout   ),
        .spr_valid  ( spr_valid  ),
        .spr_ready  ( spr_ready  ),
        .spr_x      ( spr_x      ),
        .spr_row    ( spr_row    ),
        .spr_code   ( spr_code   ),
        .spr_pal    ( spr_pal    ),
        .spr_hflip  ( spr_hflip  )
    );

    obj_draw u_draw (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .hinit      ( hinit      ),
        .spr_valid  ( spr_valid  ),
        .spr_ready  ( spr_ready  ),
        .spr_x      ( spr_x      ),
        .spr_row    ( spr_row    ),
        .spr_code   ( spr_code   ),
        .spr_pal    ( spr_pal    ),
        .spr_hflip  ( spr_hflip  ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .buf_we     ( buf_we     ),
        .buf_addr   ( buf_addr   ),
        .buf_data   ( buf_data   )
    );

    obj_linebuf u_linebuf (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .hinit      ( hinit      ),
        .pxl_cen    ( pxl_cen    ),
        .LHBL       ( LHBL       ),
        .LVBL       ( LVBL       ),
        .hdump      ( hdump      ),
        .buf_we     ( buf_we     ),
        .buf_addr   ( buf_addr   ),
        .buf_data   ( buf_data   ),
        .pxl        ( pxl        )
    );

endmodule

//--- verif/obj_clkgen.sv
/*
    Testbench clock and reset
    Period of 100 time units, reset held low for 3 cycles
*/
module obj_clkgen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        // Released away from the active edge
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- verif/obj_tb.sv
/*
    Sprite layer testbench
    Video timing, CPU table writes, a ROM with random latency and a
    reference line renderer that checks every visible pixel
*/
module obj_tb;

    // Four frames plus a few lines of slack
    localparam int MAX_CYCLES = 4 * obj_pkg::FRAME_LINES * obj_pkg::LINE_CLKS
                              + 8 * obj_pkg::LINE_CLKS;

    logic                        clk;
    logic                        arst_n;
    logic                        pxl_cen;
    logic                        LHBL;
    logic                        LVBL;
    logic                        hinit;
    logic [obj_pkg::POS_W-1:0]   vdump;
    logic [obj_pkg::LINE_AW-1:0] hdump;
    logic [obj_pkg::TBL_AW-1:0]  cpu_addr;
    logic [obj_pkg::TBL_DW-1:0]  cpu_dout;
    logic [1:0]                  cpu_dsn;
    logic                        cpu_rnw;
    logic                        objram_cs;
    logic                        obj_copy;
    logic [obj_pkg::TBL_DW-1:0]  obj_dout;
    logic                        rom_cs;
    logic [obj_pkg::ROM_AW-1:0]  rom_addr;
    logic [obj_pkg::ROM_DW-1:0]  rom_data;
    logic                        rom_ok;
    logic [obj_pkg::PXL_W-1:0]   pxl;

    // Expected contents of both tables
    logic [obj_pkg::TBL_DW-1:0]  cpu_model [0:obj_pkg::COPY_LEN-1];
    logic [obj_pkg::TBL_DW-1:0]  shd_model [0:obj_pkg::COPY_LEN-1];

    integer seed = 32'h986a;
    int     hcnt;
    int     vcnt;
    int     cycles;
    int     rom_cnt;
    int     rom_hold;
    logic   compare_on;
    logic   chk_en;
    logic   chk_blank;
    int     chk_line;
    int     chk_col;

    obj_clkgen u_clkgen (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    obj_top UUT (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .pxl_cen   ( pxl_cen   ),
        .LHBL      ( LHBL      ),
        .LVBL      ( LVBL      ),
        .hinit     ( hinit     ),
        .vdump     ( vdump     ),
        .hdump     ( hdump     ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_dout  ( cpu_dout  ),
        .cpu_dsn   ( cpu_dsn   ),
        .cpu_rnw   ( cpu_rnw   ),
        .objram_cs ( objram_cs ),
        .obj_copy  ( obj_copy  ),
        .obj_dout  ( obj_dout  ),
        .rom_cs    ( rom_cs    ),
        .rom_addr  ( rom_addr  ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .pxl       ( pxl       )
    );

    task automatic stop_failed();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_pxl(input logic [obj_pkg::PXL_W-1:0] got,
                             input logic [obj_pkg::PXL_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_word(input logic [obj_pkg::TBL_DW-1:0] got,
                              input logic [obj_pkg::TBL_DW-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    // Graphics ROM contents mixed from the address bits
    function automatic logic [obj_pkg::ROM_DW-1:0] rom_word(input logic [obj_pkg::ROM_AW-1:0] a);
        return (32'(a) * 32'h9e3779b1) ^ {a[7:0], a, 7'h5a};
    endfunction

    // Expected pixel of one line where the lowest visible entry wins
    function automatic logic [obj_pkg::PXL_W-1:0] ref_pixel(input int line, input int col);
        logic [obj_pkg::TBL_DW-1:0] w0;
        logic [obj_pkg::TBL_DW-1:0] w1;
        logic [obj_pkg::TBL_DW-1:0] w2;
        logic [obj_pkg::TBL_DW-1:0] w3;
        int                         dy;
        int                         dx;
        int                         c;
        logic [obj_pkg::ROM_DW-1:0] d;
        logic [3:0]                 n;
        for (int i = 0; i < obj_pkg::OBJ_NUM; i++) begin
            w0 = shd_model[i * obj_pkg::OBJ_WORDS + obj_pkg::W_YPOS];
            w1 = shd_model[i * obj_pkg::OBJ_WORDS + obj_pkg::W_XPOS];
            w2 = shd_model[i * obj_pkg::OBJ_WORDS + obj_pkg::W_CODE];
            w3 = shd_model[i * obj_pkg::OBJ_WORDS + obj_pkg::W_PAL];
            dy = (line - int'(w0[7:0])) & 255;
            dx = (col - int'(w1[7:0])) & 255;
            if (w0[15] && dy < obj_pkg::OBJ_SIZE && dx < obj_pkg::OBJ_SIZE) begin
                // Column within the unflipped sprite
                c = w1[8] ? 15 - dx : dx;
                d = rom_word({w2[11:0], 4'(dy), c[3]});
                n = d[(7 - c % 8) * 4 +: 4];
                if (n != 0) begin
                    return {w3[3:0], n};
                end
            end
        end
        return '0;
    endfunction

    // Video timing of 1280 clocks per line and 264 lines
    initial begin
        hcnt = 0;
        vcnt = 0;
    end

    always @(negedge clk) begin
        if (hcnt == obj_pkg::LINE_CLKS - 1) begin
            hcnt = 0;
            vcnt = (vcnt == obj_pkg::FRAME_LINES - 1) ? 0 : vcnt + 1;
        end else begin
            hcnt = hcnt + 1;
        end
    end

    // Lines 0 to 7 are blank and vdump wraps so that 8 to 263 show 8..255 then 0..7
    always_comb begin
        pxl_cen = (hcnt % obj_pkg::PXL_DIV) == 0;
        hdump   = obj_pkg::LINE_AW'(hcnt / obj_pkg::PXL_DIV);
        LHBL    = (hcnt / obj_pkg::PXL_DIV) < obj_pkg::LINE_W;
        LVBL    = vcnt >= 8;
        hinit   = hcnt == 0;
        vdump   = obj_pkg::POS_W'(vcnt);
    end

    // ROM model with 1 to 8 clocks of latency
    initial begin
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_cnt  = 0;
    end

    always @(negedge clk) begin
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            if (rom_cnt == 0) begin
                rom_cnt = 1 + ($unsigned($random(seed)) % 8);
            end
            rom_cnt = rom_cnt - 1;
            if (rom_cnt == 0) begin
                rom_data = rom_word(rom_addr);
                rom_ok   = 1'b1;
            end
        end
    end

    // Run length and ROM hang watch
    initial begin
        cycles   = 0;
        rom_hold = 0;
    end

    always @(posedge clk) begin
        cycles   = cycles + 1;
        rom_hold = rom_cs ? rom_hold + 1 : 0;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            stop_failed();
        end
        if (rom_hold > 64) begin
            $display("ROM request hung: rom_cs high for more than 64 clocks");
            stop_failed();
        end
    end

    // Pixel shown one enable after its read
    always @(posedge clk) begin
        chk_en    <= compare_on && pxl_cen && LHBL && LVBL && hdump != 0;
        // Blanked in any enable outside the active area
        chk_blank <= compare_on && pxl_cen && !(LHBL && LVBL);
        chk_col   <= int'(hdump) - 1;
        chk_line  <= int'(vdump);
    end

    always @(negedge clk) begin
        if (chk_en) begin
            check_pxl(pxl, ref_pixel(chk_line, chk_col),
                      $sformatf("pxl line %0d col %0d", chk_line, chk_col));
        end
        if (chk_blank) begin
            check_pxl(pxl, '0, $sformatf("blanked pxl line %0d", chk_line));
        end
    end

    task automatic cpu_write(input int a, input logic [15:0] d, input logic [1:0] dsn);
        @(negedge clk);
        cpu_addr  = obj_pkg::TBL_AW'(a);
        cpu_dout  = d;
        cpu_dsn   = dsn;
        cpu_rnw   = 1'b0;
        objram_cs = 1'b1;
        if (!dsn[1]) cpu_model[a][15:8] = d[15:8];
        if (!dsn[0]) cpu_model[a][7:0] = d[7:0];
        @(negedge clk);
        objram_cs = 1'b0;
        cpu_rnw   = 1'b1;
    endtask

    task automatic cpu_check(input int a);
        @(negedge clk);
        cpu_addr  = obj_pkg::TBL_AW'(a);
        cpu_rnw   = 1'b1;
        objram_cs = 1'b1;
        @(negedge clk);
        check_word(obj_dout, cpu_model[a], $sformatf("obj_dout word %0d", a));
        objram_cs = 1'b0;
    endtask

    // Eight sprites per 32-line window keeps any line at 8 or fewer
    task automatic load_table(input int shift);
        int y;
        for (int i = 0; i < obj_pkg::OBJ_NUM; i++) begin
            y = ((i / 8) * 32 + ($unsigned($random(seed)) % 13) + shift) & 255;
            cpu_write(i * 4, {($random(seed) & 7) != 0, 7'($random(seed)), 8'(y)}, 2'b00);
            cpu_write(i * 4 + 1, 16'($random(seed)), 2'b00);
            cpu_write(i * 4 + 2, 16'($random(seed)), 2'b00);
            cpu_write(i * 4 + 3, 16'($random(seed)), 2'b00);
        end
        // Entries 0 and 1 overlap and entry 2 is flipped at the right edge
        y = cpu_model[0][7:0];
        cpu_write(0, {1'b1, 7'h00, 8'(y)}, 2'b00);
        cpu_write(1, {7'h00, 1'b0, 8'd100}, 2'b00);
        cpu_write(4, {1'b1, 7'h11, 8'(y)}, 2'b00);
        cpu_write(5, {7'h00, 1'b0, 8'd106}, 2'b00);
        cpu_write(8, {1'b1, 7'h00, 8'(y + 3)}, 2'b00);
        cpu_write(9, {7'h00, 1'b1, 8'd250}, 2'b00);
    endtask

    task automatic wait_line(input int v);
        @(posedge clk);
        while (!(vcnt == v && hcnt == 0)) @(posedge clk);
    endtask

    task automatic copy_table();
        @(negedge clk);
        obj_copy = 1'b1;
        shd_model = cpu_model;
        @(negedge clk);
        obj_copy = 1'b0;
    endtask

    initial begin
        cpu_addr   = '0;
        cpu_dout   = '0;
        cpu_dsn    = 2'b11;
        cpu_rnw    = 1'b1;
        objram_cs  = 1'b0;
        obj_copy   = 1'b0;
        compare_on = 1'b0;
        @(posedge arst_n);

        // Every byte-enable combination
        for (int k = 0; k < 4; k++) begin
            cpu_write(k, 16'h1234 + 16'(k), 2'b00);
            cpu_write(k, 16'ha5c3, 2'(k));
            cpu_check(k);
        end

        // Table A is shifted so the last window wraps past line 255
        load_table(20);
        cpu_check(9);
        wait_line(1);
        copy_table();
        compare_on = 1'b1;

        // Frame with table A and then table B written in mid-frame
        wait_line(1);
        wait_line(100);
        load_table(200);
        wait_line(1);
        copy_table();
        wait_line(1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- build.f
verilog/obj_pkg.sv
verilog/obj_buffer.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_linebuf.sv
verilog/obj_top.sv
verif/obj_clkgen.sv
verif/obj_tb.sv

//--- Bender.yml
package:
  name: obj_layer

sources:
  - verilog/obj_pkg.sv
  - verilog/obj_buffer.sv
  - verilog/obj_scan.sv
  - verilog/obj_draw.sv
  - verilog/obj_linebuf.sv
  - verilog/obj_top.sv
  - target: simulation
    files:
      - verif/obj_clkgen.sv
      - verif/obj_tb.sv
